// File: rtl/perifPkg.sv
package perifPkg;

  // bus and pin widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 16;
  localparam int GPIO_W = 4;
  localparam int SEL_W  = 4;

  typedef logic [ADDR_W-1:0] apbAddrT;
  typedef logic [DATA_W-1:0] regDataT;
  typedef logic [GPIO_W-1:0] gpioT;
  typedef logic [SEL_W-1:0]  regSelT;

  // low address bits decoded inside the block, 32 bytes
  localparam int BLOCK_SPAN_BITS = 5;

  // word-aligned register offsets within the block
  localparam logic [3:0] REG_TIMER_LOAD = 4'h0;
  localparam logic [3:0] REG_TIMER_CTRL = 4'h4;
  localparam logic [3:0] REG_GPIO       = 4'h8;
  localparam logic [3:0] REG_GPIO_IN    = 4'hC;

  // bit positions in the one-hot register select
  localparam int SEL_LOAD    = 0;
  localparam int SEL_CTRL    = 1;
  localparam int SEL_GPIO    = 2;
  localparam int SEL_GPIO_IN = 3;

  // timer control register fields
  localparam int CTRL_COUNT_EN_BIT = 2;
  localparam int CTRL_RELOAD_BIT   = 3;

  typedef enum logic [1:0] {
    TICK_NONE   = 2'd0,
    TICK_1K     = 2'd1,
    TICK_1M     = 2'd2,
    TICK_ALWAYS = 2'd3
  } tickSelT;

  typedef enum logic [1:0] {
    RSP_IDLE = 2'd0,
    RSP_WAIT = 2'd1,
    RSP_DONE = 2'd2
  } rspStateT;

endpackage

// File: rtl/ioAddrDecode.sv
`timescale 1ns/1ps

module ioAddrDecode import perifPkg::*; #(
  parameter apbAddrT addrBase = 16'h0000
) (
  input  logic    PSEL,
  input  apbAddrT PADDR,
  output regSelT  sel,
  output logic    hit,
  output logic    addrErr
);

  logic [BLOCK_SPAN_BITS-1:0] offset;
  logic [2:0]                 wordIdx;

  assign offset  = PADDR[BLOCK_SPAN_BITS-1:0];
  // byte lanes 1:0 are ignored, all accesses are full words
  assign wordIdx = offset[BLOCK_SPAN_BITS-1:2];

  // block select, upper bits against the base
  assign hit = PSEL &&
    (PADDR[ADDR_W-1:BLOCK_SPAN_BITS] == addrBase[ADDR_W-1:BLOCK_SPAN_BITS]);

  // one register per word in the lower half of the block
  assign sel[SEL_LOAD]    = hit && (wordIdx == {1'b0, REG_TIMER_LOAD[3:2]});
  assign sel[SEL_CTRL]    = hit && (wordIdx == {1'b0, REG_TIMER_CTRL[3:2]});
  assign sel[SEL_GPIO]    = hit && (wordIdx == {1'b0, REG_GPIO[3:2]});
  assign sel[SEL_GPIO_IN] = hit && (wordIdx == {1'b0, REG_GPIO_IN[3:2]});

  // upper half of the span maps to nothing
  assign addrErr = hit && (sel == '0);

  // a hit resolves to exactly one register or to the error, a miss to nothing
  always_comb begin
    assert #0 (hit ? $onehot({sel, addrErr}) : ({sel, addrErr} == '0))
      else $error("address decode not one-hot, sel=%b addrErr=%b", sel, addrErr);
  end

endmodule

// File: rtl/perifTimer.sv
`timescale 1ns/1ps

module perifTimer import perifPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  regDataT wrData,
  input  logic    wrLoad,
  input  logic    wrCtrl,
  input  logic    sync1M,
  input  logic    sync1K,
  output regDataT count,
  output regDataT ctrl,
  output logic    timerActive
);

  regDataT reloadVal;
  regDataT counter;
  tickSelT tickSel;
  logic    countEn;
  logic    tick;
  logic    counterNz;
  logic    reloadCmd;
  logic    decEn;

  // tick source
  always_comb begin
    case (tickSel)
      TICK_ALWAYS: tick = 1'b1;
      TICK_1M:     tick = sync1M;
      TICK_1K:     tick = sync1K;
      default:     tick = 1'b0;
    endcase
  end

  assign counterNz = |counter;
  assign reloadCmd = wrCtrl && wrData[CTRL_RELOAD_BIT];
  // stops at zero, no wrap
  assign decEn     = countEn && tick && counterNz;

  always_ff @(posedge clk) begin
    if (rst) begin
      reloadVal   <= '0;
      counter     <= '0;
      tickSel     <= TICK_NONE;
      countEn     <= 1'b0;
      timerActive <= 1'b0;
    end else begin
      // load write wins over reload and tick
      if (wrLoad) begin
        reloadVal <= wrData;
        counter   <= wrData;
      end else if (reloadCmd) begin
        counter <= reloadVal;
      end else if (decEn) begin
        counter <= counter - regDataT'(1);
      end
      if (wrCtrl) begin
        tickSel <= tickSelT'(wrData[1:0]);
        countEn <= wrData[CTRL_COUNT_EN_BIT];
      end
      timerActive <= counterNz;
    end
  end

  assign count = counter;
  // reload bit is a command, reads back as zero
  assign ctrl  = {{(DATA_W-3){1'b0}}, countEn, tickSel};

  // an idle counter at zero stays there until software loads it again
  property noWrapP;
    @(posedge clk) disable iff (rst)
      (counter == '0 && !wrLoad && !reloadCmd) |=> (counter == '0);
  endproperty
  assert property (noWrapP) else $error("timer counter wrapped from zero");

endmodule

// File: rtl/perifGpio.sv
`timescale 1ns/1ps

module perifGpio import perifPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  regDataT wrData,
  input  logic    wrGpio,
  input  gpioT    gpioIn,
  output gpioT    gpioOut,
  output gpioT    gpioOe,
  output regDataT outRead,
  output regDataT inRead
);

  gpioT inSample;

  // output value in the low nibble, enables in the next one
  always_ff @(posedge clk) begin
    if (rst) begin
      gpioOut <= '0;
      gpioOe  <= '0;
    end else if (wrGpio) begin
      gpioOut <= wrData[GPIO_W-1:0];
      gpioOe  <= wrData[2*GPIO_W-1:GPIO_W];
    end
  end

  // pins sampled every cycle
  always_ff @(posedge clk) begin
    inSample <= gpioIn;
  end

  assign outRead = {{(DATA_W-2*GPIO_W){1'b0}}, gpioOe, gpioOut};
  assign inRead  = {{(DATA_W-GPIO_W){1'b0}}, inSample};

endmodule

// File: rtl/apbResponse.sv
`timescale 1ns/1ps

module apbResponse import perifPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    PSEL,
  input  logic    PENABLE,
  input  logic    PWRITE,
  input  regSelT  sel,
  input  logic    addrErr,
  input  regDataT timerCount,
  input  regDataT timerCtrl,
  input  regDataT gpioOutRead,
  input  regDataT gpioInRead,
  output regDataT PRDATA,
  output logic    PREADY,
  output logic    PSLVERR,
  output logic    wrStrobe
);

  rspStateT state;
  rspStateT stateNext;
  regDataT  readMux;
  logic     inBlock;

  // either a register or the unmapped part of the block
  assign inBlock = (|sel) || addrErr;

  always_comb begin
    stateNext = state;
    case (state)
      // leave idle on the setup phase of a transfer to this block
      RSP_IDLE: if (PSEL && !PENABLE && inBlock) stateNext = RSP_WAIT;
      RSP_WAIT: stateNext = (PSEL && PENABLE) ? RSP_DONE : RSP_IDLE;
      default:  stateNext = RSP_IDLE;
    endcase
  end

  // and-or mux over the one-hot select
  assign readMux = ({DATA_W{sel[SEL_LOAD]}}    & timerCount)  |
                   ({DATA_W{sel[SEL_CTRL]}}    & timerCtrl)   |
                   ({DATA_W{sel[SEL_GPIO]}}    & gpioOutRead) |
                   ({DATA_W{sel[SEL_GPIO_IN]}} & gpioInRead);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= RSP_IDLE;
      PRDATA  <= '0;
      PSLVERR <= 1'b0;
    end else begin
      state <= stateNext;
      // sampled in the first access cycle, presented in the second
      if (state == RSP_WAIT) begin
        PRDATA <= (PWRITE || addrErr) ? '0 : readMux;
      end
      PSLVERR <= (state == RSP_WAIT) && addrErr;
    end
  end

  assign PREADY   = (state == RSP_DONE);
  assign wrStrobe = PREADY && PWRITE && !PSLVERR;

  assert property (@(posedge clk) disable iff (rst) PREADY |-> (PSEL && PENABLE))
    else $error("PREADY outside an access phase");
  assert property (@(posedge clk) disable iff (rst) PSLVERR |-> PREADY)
    else $error("PSLVERR without PREADY");

endmodule

// File: rtl/apbPerifTop.sv
`timescale 1ns/1ps

module apbPerifTop import perifPkg::*; #(
  parameter apbAddrT addrBase = 16'h4000
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    PSEL,
  input  logic    PENABLE,
  input  logic    PWRITE,
  input  apbAddrT PADDR,
  input  regDataT PWDATA,
  output regDataT PRDATA,
  output logic    PREADY,
  output logic    PSLVERR,
  input  logic    sync1M,
  input  logic    sync1K,
  input  gpioT    gpioIn,
  output gpioT    gpioOut,
  output gpioT    gpioOe,
  output logic    timerActive
);

  regSelT  sel;
  logic    addrErr;
  logic    wrStrobe;
  logic    wrLoad;
  logic    wrCtrl;
  logic    wrGpio;
  regDataT timerCount;
  regDataT timerCtrl;
  regDataT gpioOutRead;
  regDataT gpioInRead;

  // block hit is carried by sel and addrErr, so the hit output stays open
  ioAddrDecode #(.addrBase(addrBase)) uDecode (
    .PSEL(PSEL), .PADDR(PADDR),
    .sel(sel), .hit(), .addrErr(addrErr)
  );

  // per-register write enables
  assign wrLoad = wrStrobe && sel[SEL_LOAD];
  assign wrCtrl = wrStrobe && sel[SEL_CTRL];
  assign wrGpio = wrStrobe && sel[SEL_GPIO];

  perifTimer uTimer (
    .clk(clk), .rst(rst),
    .wrData(PWDATA), .wrLoad(wrLoad), .wrCtrl(wrCtrl),
    .sync1M(sync1M), .sync1K(sync1K),
    .count(timerCount), .ctrl(timerCtrl), .timerActive(timerActive)
  );

  perifGpio uGpio (
    .clk(clk), .rst(rst),
    .wrData(PWDATA), .wrGpio(wrGpio), .gpioIn(gpioIn),
    .gpioOut(gpioOut), .gpioOe(gpioOe),
    .outRead(gpioOutRead), .inRead(gpioInRead)
  );

  apbResponse uResponse (
    .clk(clk), .rst(rst),
    .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
    .sel(sel), .addrErr(addrErr),
    .timerCount(timerCount), .timerCtrl(timerCtrl),
    .gpioOutRead(gpioOutRead), .gpioInRead(gpioInRead),
    .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR), .wrStrobe(wrStrobe)
  );

endmodule

// File: testbench/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // released on a falling edge like every other DUT input
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// File: testbench/tbChecker.sv
`timescale 1ns/1ps

module tbChecker import perifPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    PREADY,
  input  regDataT PRDATA,
  input  logic    PSLVERR,
  input  gpioT    gpioOut,
  input  gpioT    gpioOe,
  input  logic    timerActive,
  input  logic    chkXfer,
  input  regDataT expRdata,
  input  logic    expSlverr,
  input  logic    chkPins,
  input  gpioT    expGpioOut,
  input  gpioT    expGpioOe,
  input  logic    expActive,
  output int      mismatchCnt,
  output int      checkCnt
);

  // rising edge sampling, DUT outputs still hold the previous cycle's values
  always @(posedge clk) begin
    if (rst) begin
      mismatchCnt = 0;
      checkCnt    = 0;
    end else begin
      // completion cycle of a transfer to this block
      if (chkXfer && PREADY) begin
        checkCnt = checkCnt + 1;
        if (PRDATA !== expRdata) begin
          mismatchCnt = mismatchCnt + 1;
          $display("MISMATCH at %0t: PRDATA is %h, expected %h", $time, PRDATA, expRdata);
        end
        if (PSLVERR !== expSlverr) begin
          mismatchCnt = mismatchCnt + 1;
          $display("MISMATCH at %0t: PSLVERR is %b, expected %b", $time, PSLVERR, expSlverr);
        end
      end
      // pin snapshot
      if (chkPins) begin
        checkCnt = checkCnt + 1;
        if (gpioOut !== expGpioOut) begin
          mismatchCnt = mismatchCnt + 1;
          $display("MISMATCH at %0t: gpioOut is %h, expected %h", $time, gpioOut, expGpioOut);
        end
        if (gpioOe !== expGpioOe) begin
          mismatchCnt = mismatchCnt + 1;
          $display("MISMATCH at %0t: gpioOe is %h, expected %h", $time, gpioOe, expGpioOe);
        end
        if (timerActive !== expActive) begin
          mismatchCnt = mismatchCnt + 1;
          $display("MISMATCH at %0t: timerActive is %b, expected %b",
                   $time, timerActive, expActive);
        end
      end
    end
  end

endmodule

// File: testbench/tbApbPerif.sv
`timescale 1ns/1ps

module tbApbPerif import perifPkg::*; ();

  localparam apbAddrT BASE = 16'h4000;
  localparam int READY_TIMEOUT = 8;
  localparam int IDLE_TIMEOUT  = 200;
  localparam int RESET_TIMEOUT = 20;

  localparam int OP_WR    = 0;
  localparam int OP_RD    = 1;
  localparam int OP_PINS  = 2;
  localparam int OP_PULSE = 3;
  localparam int OP_IDLE  = 4;
  localparam int OP_NORSP = 5;

  logic    clk;
  logic    rst;
  logic    PSEL;
  logic    PENABLE;
  logic    PWRITE;
  apbAddrT PADDR;
  regDataT PWDATA;
  regDataT PRDATA;
  logic    PREADY;
  logic    PSLVERR;
  logic    sync1M;
  logic    sync1K;
  gpioT    gpioIn;
  gpioT    gpioOut;
  gpioT    gpioOe;
  logic    timerActive;

  logic    chkXfer;
  regDataT expRdata;
  logic    expSlverr;
  logic    chkPins;
  gpioT    expGpioOut;
  gpioT    expGpioOe;
  logic    expActive;
  int      mismatchCnt;
  int      checkCnt;
  int      otherErr;
  logic [31:0] rndState;

  // stimulus table, one entry per index
  int      opQ[$];
  apbAddrT addrQ[$];
  regDataT wdQ[$];
  regDataT expQ[$];
  logic    errQ[$];
  gpioT    gpiQ[$];

  tbClock uClk (.clk(clk), .rst(rst));

  apbPerifTop #(.addrBase(BASE)) UUT (
    .clk(clk), .rst(rst),
    .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA),
    .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
    .sync1M(sync1M), .sync1K(sync1K), .gpioIn(gpioIn),
    .gpioOut(gpioOut), .gpioOe(gpioOe), .timerActive(timerActive)
  );

  tbChecker uCheck (
    .clk(clk), .rst(rst), .PREADY(PREADY), .PRDATA(PRDATA), .PSLVERR(PSLVERR),
    .gpioOut(gpioOut), .gpioOe(gpioOe), .timerActive(timerActive),
    .chkXfer(chkXfer), .expRdata(expRdata), .expSlverr(expSlverr),
    .chkPins(chkPins), .expGpioOut(expGpioOut), .expGpioOe(expGpioOe),
    .expActive(expActive), .mismatchCnt(mismatchCnt), .checkCnt(checkCnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic apbAddrT regAddr(input logic [4:0] offset);
    return BASE + apbAddrT'(offset);
  endfunction

  // tickSel in 1:0, countEn in 2, reload command in 3
  function automatic regDataT ctrlWord(input tickSelT t, input logic en, input logic reload);
    return {12'h000, reload, en, t};
  endfunction

  // gpioOut in 3:0, gpioOe in 7:4, timerActive in 8
  function automatic regDataT pinWord(input logic [7:0] gpioByte, input logic active);
    return {7'h00, active, gpioByte};
  endfunction

  task automatic addEntry(input int op, input apbAddrT addr, input regDataT wdata,
                          input regDataT expData, input logic expErr, input gpioT pins);
    opQ.push_back(op);
    addrQ.push_back(addr);
    wdQ.push_back(wdata);
    expQ.push_back(expData);
    errQ.push_back(expErr);
    gpiQ.push_back(pins);
  endtask

  task automatic buildTable();
    logic [7:0] gpioByte;
    gpioT       curIn;
    regDataT    loadVal;
    regDataT    cnt;
    int         pulseRuns[2];
    int         i;
    curIn = '0;
    pulseRuns[0] = 4;
    pulseRuns[1] = 9;
    // gpio output and its readback
    for (i = 0; i < 3; i++) begin
      rndState = xorshift32(rndState);
      gpioByte = rndState[7:0];
      addEntry(OP_WR, regAddr(REG_GPIO), {8'h00, gpioByte}, '0, 1'b0, curIn);
      addEntry(OP_PINS, '0, '0, pinWord(gpioByte, 1'b0), 1'b0, curIn);
      addEntry(OP_RD, regAddr(REG_GPIO), '0, {8'h00, gpioByte}, 1'b0, curIn);
    end
    // gpio input sample
    for (i = 0; i < 3; i++) begin
      rndState = xorshift32(rndState);
      curIn = rndState[11:8];
      addEntry(OP_RD, regAddr(REG_GPIO_IN), '0, {12'h000, curIn}, 1'b0, curIn);
    end
    // timer load with counting off
    rndState = xorshift32(rndState);
    loadVal = rndState[15:0];
    addEntry(OP_WR, regAddr(REG_TIMER_LOAD), loadVal, '0, 1'b0, curIn);
    addEntry(OP_RD, regAddr(REG_TIMER_LOAD), '0, loadVal, 1'b0, curIn);
    addEntry(OP_PINS, '0, '0, pinWord(gpioByte, loadVal != '0), 1'b0, curIn);
    addEntry(OP_RD, regAddr(REG_TIMER_CTRL), '0, '0, 1'b0, curIn);
    addEntry(OP_WR, regAddr(REG_TIMER_LOAD), '0, '0, 1'b0, curIn);
    addEntry(OP_RD, regAddr(REG_TIMER_LOAD), '0, '0, 1'b0, curIn);
    addEntry(OP_PINS, '0, '0, pinWord(gpioByte, 1'b0), 1'b0, curIn);
    // 1 kHz strobe counting, second run runs past zero
    loadVal = 16'd10;
    cnt = loadVal;
    addEntry(OP_WR, regAddr(REG_TIMER_LOAD), loadVal, '0, 1'b0, curIn);
    addEntry(OP_WR, regAddr(REG_TIMER_CTRL), ctrlWord(TICK_1K, 1'b1, 1'b0), '0, 1'b0, curIn);
    addEntry(OP_RD, regAddr(REG_TIMER_CTRL), '0, ctrlWord(TICK_1K, 1'b1, 1'b0), 1'b0, curIn);
    for (i = 0; i < 2; i++) begin
      addEntry(OP_PULSE, '0, regDataT'(pulseRuns[i]), '0, 1'b0, curIn);
      cnt = (cnt > regDataT'(pulseRuns[i])) ? cnt - regDataT'(pulseRuns[i]) : '0;
      addEntry(OP_RD, regAddr(REG_TIMER_LOAD), '0, cnt, 1'b0, curIn);
      addEntry(OP_PINS, '0, '0, pinWord(gpioByte, cnt != '0), 1'b0, curIn);
    end
    addEntry(OP_WR, regAddr(REG_TIMER_CTRL), ctrlWord(TICK_1K, 1'b1, 1'b1), '0, 1'b0, curIn);
    addEntry(OP_RD, regAddr(REG_TIMER_LOAD), '0, loadVal, 1'b0, curIn);
    addEntry(OP_RD, regAddr(REG_TIMER_CTRL), '0, ctrlWord(TICK_1K, 1'b1, 1'b0), 1'b0, curIn);
    // free-running countdown
    addEntry(OP_WR, regAddr(REG_TIMER_LOAD), 16'd40, '0, 1'b0, curIn);
    addEntry(OP_WR, regAddr(REG_TIMER_CTRL), ctrlWord(TICK_ALWAYS, 1'b1, 1'b0), '0, 1'b0, curIn);
    addEntry(OP_IDLE, '0, '0, '0, 1'b0, curIn);
    addEntry(OP_RD, regAddr(REG_TIMER_LOAD), '0, '0, 1'b0, curIn);
    addEntry(OP_PINS, '0, '0, pinWord(gpioByte, 1'b0), 1'b0, curIn);
    addEntry(OP_RD, regAddr(REG_TIMER_LOAD), '0, '0, 1'b0, curIn);
    // unmapped words inside the block, then misses outside it
    addEntry(OP_WR, regAddr(5'h10), 16'h00A2, '0, 1'b1, curIn);
    addEntry(OP_RD, regAddr(5'h14), '0, '0, 1'b1, curIn);
    addEntry(OP_RD, regAddr(5'h1C), '0, '0, 1'b1, curIn);
    addEntry(OP_RD, regAddr(REG_TIMER_LOAD), '0, '0, 1'b0, curIn);
    addEntry(OP_RD, regAddr(REG_GPIO), '0, {8'h00, gpioByte}, 1'b0, curIn);
    addEntry(OP_RD, regAddr(REG_TIMER_CTRL), '0, ctrlWord(TICK_ALWAYS, 1'b1, 1'b0), 1'b0, curIn);
    addEntry(OP_NORSP, BASE + 16'h0020, 16'h00FF, '0, 1'b0, curIn);
    addEntry(OP_NORSP, 16'h0008, 16'h00A5, '0, 1'b0, curIn);
    addEntry(OP_RD, regAddr(REG_GPIO), '0, {8'h00, gpioByte}, 1'b0, curIn);
    addEntry(OP_PINS, '0, '0, pinWord(gpioByte, 1'b0), 1'b0, curIn);
  endtask

  task automatic apbTransfer(input logic wr, input apbAddrT addr, input regDataT wdata,
                             input regDataT expData, input logic expErr,
                             input logic expectResp);
    int   waitCnt;
    logic seen;
    waitCnt = 0;
    seen = 1'b0;
    // setup phase
    @(negedge clk);
    PSEL = 1'b1;
    PENABLE = 1'b0;
    PWRITE = wr;
    PADDR = addr;
    PWDATA = wdata;
    chkXfer = expectResp;
    expRdata = expData;
    expSlverr = expErr;
    @(negedge clk);
    PENABLE = 1'b1;
    while (!seen && waitCnt < READY_TIMEOUT) begin
      @(negedge clk);
      if (PREADY) begin
        seen = 1'b1;
      end else begin
        waitCnt++;
      end
    end
    // hold through the completing edge, then release the bus
    @(negedge clk);
    PSEL = 1'b0;
    PENABLE = 1'b0;
    chkXfer = 1'b0;
    if (expectResp && !seen) begin
      otherErr++;
      $display("no PREADY within %0d cycles for the access to %h", READY_TIMEOUT, addr);
    end else if (!expectResp && seen) begin
      otherErr++;
      $display("address %h outside the block got a response", addr);
    end else if (!expectResp) begin
      $display("address %h outside the block gave no response, as expected", addr);
    end else if (waitCnt != 0) begin
      otherErr++;
      $display("PREADY for the access to %h came %0d cycles late", addr, waitCnt);
    end
  endtask

  task automatic checkPins(input regDataT exp);
    @(negedge clk);
    expGpioOut = exp[3:0];
    expGpioOe = exp[7:4];
    expActive = exp[8];
    chkPins = 1'b1;
    @(negedge clk);
    chkPins = 1'b0;
  endtask

  // single-cycle 1 kHz strobes, the 1 MHz strobe toggling every cycle
  task automatic pulse1K(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(negedge clk);
      sync1K = 1'b1;
      sync1M = ~sync1M;
      @(negedge clk);
      sync1K = 1'b0;
      sync1M = ~sync1M;
      @(negedge clk);
      sync1M = ~sync1M;
    end
  endtask

  task automatic waitTimerIdle();
    int n;
    n = 0;
    while (timerActive && n < IDLE_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (timerActive) begin
      otherErr++;
      $display("timerActive still high after %0d cycles of countdown", IDLE_TIMEOUT);
    end
  endtask

  initial begin
    int idx;
    int n;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = '0;
    PWDATA = '0;
    sync1M = 1'b0;
    sync1K = 1'b0;
    gpioIn = '0;
    chkXfer = 1'b0;
    expRdata = '0;
    expSlverr = 1'b0;
    chkPins = 1'b0;
    expGpioOut = '0;
    expGpioOe = '0;
    expActive = 1'b0;
    otherErr = 0;
    rndState = 32'h4187;
    buildTable();
    n = 0;
    while (rst !== 1'b0 && n < RESET_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      otherErr++;
      $display("reset was never released");
    end
    for (idx = 0; idx < opQ.size(); idx++) begin
      // pins settle for two cycles before each step
      @(negedge clk);
      gpioIn = gpiQ[idx];
      repeat (2) @(negedge clk);
      case (opQ[idx])
        OP_WR:    apbTransfer(1'b1, addrQ[idx], wdQ[idx], expQ[idx], errQ[idx], 1'b1);
        OP_RD:    apbTransfer(1'b0, addrQ[idx], '0, expQ[idx], errQ[idx], 1'b1);
        OP_PINS:  checkPins(expQ[idx]);
        OP_PULSE: pulse1K(int'(wdQ[idx]));
        OP_IDLE:  waitTimerIdle();
        OP_NORSP: apbTransfer(1'b1, addrQ[idx], wdQ[idx], '0, 1'b0, 1'b0);
        default: begin
          otherErr++;
          $display("table entry %0d holds an unknown operation", idx);
        end
      endcase
    end
    @(negedge clk);
    $display("checks %0d, mismatches %0d, other errors %0d", checkCnt, mismatchCnt, otherErr);
    if (mismatchCnt == 0 && otherErr == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
rtl/perifPkg.sv
rtl/ioAddrDecode.sv
rtl/perifTimer.sv
rtl/perifGpio.sv
rtl/apbResponse.sv
rtl/apbPerifTop.sv
testbench/tbClock.sv
testbench/tbChecker.sv
testbench/tbApbPerif.sv

// File: Bender.yml
package:
  name: apb_perif

sources:
  - rtl/perifPkg.sv
  - rtl/ioAddrDecode.sv
  - rtl/perifTimer.sv
  - rtl/perifGpio.sv
  - rtl/apbResponse.sv
  - rtl/apbPerifTop.sv
  - target: test
    files:
      - testbench/tbClock.sv
      - testbench/tbChecker.sv
      - testbench/tbApbPerif.sv
